/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --timing
TOP       ?= tb_pow_check
FILELIST  ?= compile.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJDIR) -o V$(TOP)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* compile.f */
+incdir+.
sha256d_pkg.sv
hdr_block_packer.sv
sha256_compress.sv
sha256d_sequencer.sv
target_compare.sv
pow_check_top.sv
tb_pow_check.sv

/* hdr_block_packer.sv */
// ********************
// Header block packer
// Shifts input beats into 512-bit blocks, pads the
// final block with 0x80 and the bit length, and drops
// anything after the header up to eop
// ********************
`timescale 1ns/1ps
`include "sha256d_macros.svh"

module hdr_block_packer
  import sha256d_pkg::*;
(
  input  logic         i_clk,
  input  logic         i_rst,
  input  stream_word_t i_word,
  input  logic         i_word_val,
  output logic         o_word_rdy,
  input  logic         i_blk_rdy,
  output logic         o_blk_stb,
  output sha_block_t   o_blk
);

  localparam int WORD_BITS = `WORD_BYTES * 8;
  // Beats per full 512-bit block
  localparam int BLK_WORDS = 512 / WORD_BITS;
  // Zero fill between the 0x80 byte and the length field
  localparam int PAD_ZEROS = 512 - (`HDR_WORDS - BLK_WORDS) * WORD_BITS - 8 - 64;

  logic [3:0] cnt_q;
  logic       in_hdr_q;
  logic       pend_q;
  logic       accept;
  sha_block_t blk_q;

  // Stall the source while a finished block waits
  assign o_word_rdy = ~pend_q;
  assign accept     = i_word_val & o_word_rdy;

  // Block goes out once the sequencer can take it
  assign o_blk_stb = pend_q & i_blk_rdy;
  assign o_blk     = blk_q;

  // Control path
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      cnt_q    <= '0;
      in_hdr_q <= 1'b0;
      pend_q   <= 1'b0;
    end else begin
      if (o_blk_stb)
        pend_q <= 1'b0;
      if (accept) begin
        if (i_word.sop) begin
          // New header, this beat is word 1
          cnt_q    <= 4'd1;
          in_hdr_q <= ~i_word.eop;
        end else if (in_hdr_q) begin
          cnt_q <= cnt_q + 4'd1;
          // Block 0 complete after word 8
          if (cnt_q + 4'd1 == 4'(BLK_WORDS))
            pend_q <= 1'b1;
          // Last header word, rest of the packet is dropped
          if (cnt_q + 4'd1 == 4'(`HDR_WORDS)) begin
            pend_q   <= 1'b1;
            in_hdr_q <= 1'b0;
          end
          // Short packet ends the header early
          if (i_word.eop)
            in_hdr_q <= 1'b0;
        end
      end
    end
  end

  // Block buffer, first word ends up in the top bits
  always_ff @(posedge i_clk) begin
    if (accept && (i_word.sop || in_hdr_q)) begin
      blk_q.data <= {blk_q.data[511-WORD_BITS:0], i_word.data};
      if (i_word.sop) begin
        blk_q.first <= 1'b1;
        blk_q.last  <= 1'b0;
      end else if (cnt_q + 4'd1 == 4'(`HDR_WORDS)) begin
        // Two tail words, 0x80, zero fill, header length in bits
        blk_q.data  <= {blk_q.data[WORD_BITS-1:0], i_word.data, 8'h80,
                        {PAD_ZEROS{1'b0}}, 64'(`HDR_BYTES * 8)};
        blk_q.first <= 1'b0;
        blk_q.last  <= 1'b1;
      end
    end
  end

endmodule

/* pow_check_patterns.txt */
# mode: 0 back-to-back, 1 random gaps, 2 random gaps plus trailing beats
# mode w0..w9 (first header byte on top) bits expected_digest expected_fail
0 0100000000000000 0000000000000000 0000000000000000 0000000000000000 000000003ba3edfd 7a7b12b27ac72c3e 67768f617fc81bc3 888a51323a9fb8aa 4b1e5e4a29ab5f49 ffff001d1dac2b7c 1d00ffff 000000000019d6689c085ae165831e934ff763ae46a2a6c172b3f1b60a8ce26f 0
0 010000006fe28c0a b6f1b372c1a6a246 ae63f74f931e8365 e15a089c68d61900 00000000982051fd 1e4ba744bbbe680e 1fee14677ba1a3c3 540bf7b1cdb606e8 57233e0e61bc6649 ffff001d01e36299 1d00ffff 00000000839a8e6886ab5951d76f411475428afc90947ee320161bbf18eb6048 0
0 0100000000000000 0000000000000000 0000000000000000 0000000000000000 000000003ba3edfd 7a7b12b27ac72c3e 67768f617fc81bc3 888a51323a9fb8aa 4b1e5e4a29ab5f49 ffff001d1dac2b7c 1b00ffff 000000000019d6689c085ae165831e934ff763ae46a2a6c172b3f1b60a8ce26f 1
0 0100000000000000 0000000000000000 0000000000000000 0000000000000000 000000003ba3edfd 7a7b12b27ac72c3e 67768f617fc81bc3 888a51323a9fb8aa 4b1e5e4a29ab5f49 ffff001d1dac2b7c 1b19d669 000000000019d6689c085ae165831e934ff763ae46a2a6c172b3f1b60a8ce26f 0
0 0100000000000000 0000000000000000 0000000000000000 0000000000000000 000000003ba3edfd 7a7b12b27ac72c3e 67768f617fc81bc3 888a51323a9fb8aa 4b1e5e4a29ab5f49 ffff001d1dac2b7c 1b19d668 000000000019d6689c085ae165831e934ff763ae46a2a6c172b3f1b60a8ce26f 1
0 0100000000000000 0000000000000000 0000000000000000 0000000000000000 000000003ba3edfd 7a7b12b27ac72c3e 67768f617fc81bc3 888a51323a9fb8aa 4b1e5e4a29ab5f49 ffff001d1dac2b7c 00000000 000000000019d6689c085ae165831e934ff763ae46a2a6c172b3f1b60a8ce26f 1
0 0100000000000000 0000000000000000 0000000000000000 0000000000000000 000000003ba3edfd 7a7b12b27ac72c3e 67768f617fc81bc3 888a51323a9fb8aa 4b1e5e4a29ab5f49 ffff001d1dac2b7c 1d80ffff 000000000019d6689c085ae165831e934ff763ae46a2a6c172b3f1b60a8ce26f 1
0 010000006fe28c0a b6f1b372c1a6a246 ae63f74f931e8365 e15a089c68d61900 00000000982051fd 1e4ba744bbbe680e 1fee14677ba1a3c3 540bf7b1cdb606e8 57233e0e61bc6649 ffff001d01e36299 22010000 00000000839a8e6886ab5951d76f411475428afc90947ee320161bbf18eb6048 1
1 0100000000000000 0000000000000000 0000000000000000 0000000000000000 000000003ba3edfd 7a7b12b27ac72c3e 67768f617fc81bc3 888a51323a9fb8aa 4b1e5e4a29ab5f49 ffff001d1dac2b7c 1d00ffff 000000000019d6689c085ae165831e934ff763ae46a2a6c172b3f1b60a8ce26f 0
2 010000006fe28c0a b6f1b372c1a6a246 ae63f74f931e8365 e15a089c68d61900 00000000982051fd 1e4ba744bbbe680e 1fee14677ba1a3c3 540bf7b1cdb606e8 57233e0e61bc6649 ffff001d01e36299 1d00ffff 00000000839a8e6886ab5951d76f411475428afc90947ee320161bbf18eb6048 0

/* pow_check_top.sv */
// ********************
// Proof-of-work checker top
// Packer, double SHA-256 and target compare
// ********************
`timescale 1ns/1ps

module pow_check_top
  import sha256d_pkg::*;
(
  input  logic         i_clk,
  input  logic         i_rst,
  input  stream_word_t i_word,
  input  logic         i_word_val,
  output logic         o_word_rdy,
  input  logic  [31:0] i_bits,
  output logic         o_val,
  output logic         o_fail,
  output digest_t      o_digest
);

  logic        blk_stb, blk_rdy;
  sha_block_t  blk;
  logic        hash_stb;
  digest_t     hash;
  logic [31:0] bits_q;
  logic [31:0] bits_hdr_q;

  // Bits taken on sop, moved on once the last block is in the core
  always_ff @(posedge i_clk) begin
    if (i_word_val && o_word_rdy && i_word.sop)
      bits_q <= i_bits;
    if (blk_stb && blk.last)
      bits_hdr_q <= bits_q;
  end

  hdr_block_packer u_packer (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_word     (i_word),
    .i_word_val (i_word_val),
    .o_word_rdy (o_word_rdy),
    .i_blk_rdy  (blk_rdy),
    .o_blk_stb  (blk_stb),
    .o_blk      (blk)
  );

  sha256d_sequencer u_seq (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_blk_stb  (blk_stb),
    .i_blk      (blk),
    .o_blk_rdy  (blk_rdy),
    .o_hash_stb (hash_stb),
    .o_hash     (hash)
  );

  target_compare u_cmp (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_hash_stb (hash_stb),
    .i_hash     (hash),
    .i_bits     (bits_hdr_q),
    .o_val      (o_val),
    .o_fail     (o_fail),
    .o_digest   (o_digest)
  );

endmodule

/* sha256_compress.sv */
// ********************
// SHA-256 compression core
// One round per cycle over a sliding 16-word
// schedule window, 66 cycles from start to done
// ********************
`timescale 1ns/1ps
`include "sha256d_macros.svh"

module sha256_compress
  import sha256d_pkg::*;
(
  input  logic         i_clk,
  input  logic         i_rst,
  input  logic         i_start,
  input  logic [511:0] i_block,
  input  digest_t      i_chain,
  output logic         o_done,
  output digest_t      o_chain
);

  localparam int RND_W = $clog2(`SHA_ROUNDS);

  // Round constants
  localparam logic [31:0] K_TAB [`SHA_ROUNDS] = '{
    32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
    32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
    32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
    32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
    32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
    32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
    32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
    32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
    32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
    32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
    32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
    32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
    32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
    32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
    32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
    32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
  };

  compress_state_e   state_q;
  logic [RND_W-1:0]  rnd_q;
  logic [31:0]       w_q [16];
  logic [31:0]       a_q, b_q, c_q, d_q, e_q, f_q, g_q, h_q;
  digest_t           chain_q;
  logic [31:0]       t1, t2, w_next;

  function automatic logic [31:0] rotr(input logic [31:0] x, input int n);
    rotr = (x >> n) | (x << (32 - n));
  endfunction

  // Round function, new schedule word for W[t+16]
  always_comb begin
    t1 = h_q + (rotr(e_q, 6) ^ rotr(e_q, 11) ^ rotr(e_q, 25))
         + ((e_q & f_q) ^ (~e_q & g_q)) + K_TAB[rnd_q] + w_q[0];
    t2 = (rotr(a_q, 2) ^ rotr(a_q, 13) ^ rotr(a_q, 22))
         + ((a_q & b_q) ^ (a_q & c_q) ^ (b_q & c_q));
    w_next = (rotr(w_q[14], 17) ^ rotr(w_q[14], 19) ^ (w_q[14] >> 10)) + w_q[9]
             + (rotr(w_q[1], 7) ^ rotr(w_q[1], 18) ^ (w_q[1] >> 3)) + w_q[0];
  end

  // Load, 64 rounds, add
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state_q <= CMP_IDLE;
      rnd_q   <= '0;
      o_done  <= 1'b0;
    end else begin
      o_done <= 1'b0;
      case (state_q)
        CMP_IDLE: begin
          rnd_q <= '0;
          if (i_start)
            state_q <= CMP_ROUNDS;
        end
        CMP_ROUNDS: begin
          rnd_q <= rnd_q + 1'b1;
          if (rnd_q == RND_W'(`SHA_ROUNDS - 1))
            state_q <= CMP_FINISH;
        end
        CMP_FINISH: begin
          o_done  <= 1'b1;
          state_q <= CMP_IDLE;
        end
        default: state_q <= CMP_IDLE;
      endcase
    end
  end

  // Working variables and schedule window
  always_ff @(posedge i_clk) begin
    case (state_q)
      CMP_IDLE: begin
        if (i_start) begin
          chain_q <= i_chain;
          {a_q, b_q, c_q, d_q, e_q, f_q, g_q, h_q} <= i_chain;
          // W[0] is the top word of the block
          for (int i = 0; i < 16; i++)
            w_q[i] <= i_block[511 - 32*i -: 32];
        end
      end
      CMP_ROUNDS: begin
        h_q <= g_q;
        g_q <= f_q;
        f_q <= e_q;
        e_q <= d_q + t1;
        d_q <= c_q;
        c_q <= b_q;
        b_q <= a_q;
        a_q <= t1 + t2;
        for (int i = 0; i < 15; i++)
          w_q[i] <= w_q[i+1];
        w_q[15] <= w_next;
      end
      CMP_FINISH: begin
        // Feed-forward into the chaining value
        o_chain <= {a_q + chain_q[255:224], b_q + chain_q[223:192],
                    c_q + chain_q[191:160], d_q + chain_q[159:128],
                    e_q + chain_q[127:96],  f_q + chain_q[95:64],
                    g_q + chain_q[63:32],   h_q + chain_q[31:0]};
      end
      default: ;
    endcase
  end

endmodule

/* sha256d_macros.svh */
// ********************
// Header format constants for the
// double SHA-256 proof-of-work checker
// ********************
`ifndef SHA256D_MACROS_SVH
`define SHA256D_MACROS_SVH

// Bytes in one block header
`define HDR_BYTES 80

// Bytes carried by one input beat
`define WORD_BYTES 8

// Input beats that make up one header
`define HDR_WORDS (`HDR_BYTES / `WORD_BYTES)

// SHA-256 rounds per 512-bit block
`define SHA_ROUNDS 64

`endif

/* sha256d_pkg.sv */
// ********************
// Shared types for the proof-of-work checker
// Stream beat, hash block, digest and FSM states
// ********************
package sha256d_pkg;

  `include "sha256d_macros.svh"

  // One input beat
  // First byte of the stream sits in data[63:56]
  typedef struct packed {
    logic [`WORD_BYTES*8-1:0] data;
    logic                     sop;
    logic                     eop;
  } stream_word_t;

  // One padded 512-bit message block for the hash core
  typedef struct packed {
    logic [511:0] data;
    // Start from the standard initial value
    logic         first;
    // Final block of the message
    logic         last;
  } sha_block_t;

  // Hash value, H0 in the top 32 bits
  typedef logic [255:0] digest_t;

  // Sequencer passes
  typedef enum logic [1:0] {
    PASS_IDLE,
    PASS_FIRST,
    PASS_SECOND,
    PASS_DONE
  } pass_e;

  // Compression core states
  typedef enum logic [1:0] {
    CMP_IDLE,
    CMP_ROUNDS,
    CMP_FINISH
  } compress_state_e;

endpackage

/* sha256d_sequencer.sv */
// ********************
// Double SHA-256 sequencer
// Chains header blocks through the core, then
// hashes the padded first digest once more
// ********************
`timescale 1ns/1ps

module sha256d_sequencer
  import sha256d_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_rst,
  input  logic       i_blk_stb,
  input  sha_block_t i_blk,
  output logic       o_blk_rdy,
  output logic       o_hash_stb,
  output digest_t    o_hash
);

  localparam digest_t SHA_IV = {32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
                                32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19};

  pass_e        state_q;
  logic         last_q;
  digest_t      chain_q;
  digest_t      hash_q;
  logic         start_hdr, start_second;
  logic         cmp_start, cmp_done;
  logic [511:0] cmp_block;
  digest_t      cmp_chain_in, cmp_chain_out;

  // Byte 0 of the digest becomes the least significant byte
  function automatic digest_t byte_rev(input digest_t d);
    for (int i = 0; i < 32; i++)
      byte_rev[8*i +: 8] = d[255 - 8*i -: 8];
  endfunction

  assign o_blk_rdy    = (state_q == PASS_IDLE);
  assign start_hdr    = o_blk_rdy & i_blk_stb;
  // Second pass starts in the same cycle the first digest lands
  assign start_second = (state_q == PASS_FIRST) & cmp_done & last_q;
  assign cmp_start    = start_hdr | start_second;

  always_comb begin
    if (start_second) begin
      // 32-byte message, 0x80, zero fill, 256-bit length
      cmp_block    = {cmp_chain_out, 8'h80, 184'd0, 64'($bits(digest_t))};
      cmp_chain_in = SHA_IV;
    end else begin
      cmp_block    = i_blk.data;
      cmp_chain_in = i_blk.first ? SHA_IV : chain_q;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state_q <= PASS_IDLE;
      last_q  <= 1'b0;
    end else begin
      case (state_q)
        PASS_IDLE:   if (start_hdr) begin
          last_q  <= i_blk.last;
          state_q <= PASS_FIRST;
        end
        PASS_FIRST:  if (cmp_done) state_q <= last_q ? PASS_SECOND : PASS_IDLE;
        PASS_SECOND: if (cmp_done) state_q <= PASS_DONE;
        default:     state_q <= PASS_IDLE;
      endcase
    end
  end

  // Held chain between header blocks, final result
  always_ff @(posedge i_clk) begin
    if (state_q == PASS_FIRST && cmp_done)
      chain_q <= cmp_chain_out;
    if (state_q == PASS_SECOND && cmp_done)
      hash_q <= byte_rev(cmp_chain_out);
  end

  assign o_hash_stb = (state_q == PASS_DONE);
  assign o_hash     = hash_q;

  sha256_compress u_compress (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_start (cmp_start),
    .i_block (cmp_block),
    .i_chain (cmp_chain_in),
    .o_done  (cmp_done),
    .o_chain (cmp_chain_out)
  );

endmodule

/* target_compare.sv */
// ********************
// Target compare
// Expands the compact bits, flags bad encodings
// and checks the hash against the target
// ********************
`timescale 1ns/1ps

module target_compare
  import sha256d_pkg::*;
(
  input  logic        i_clk,
  input  logic        i_rst,
  input  logic        i_hash_stb,
  input  digest_t     i_hash,
  input  logic [31:0] i_bits,
  output logic        o_val,
  output logic        o_fail,
  output digest_t     o_digest
);

  logic [7:0]   size;
  logic [22:0]  mant;
  logic [255:0] target;
  logic         bits_err;

  // Exponent byte and 23-bit mantissa, bit 23 is the sign
  assign size = i_bits[31:24];
  assign mant = i_bits[22:0];

  // mantissa * 256^(size - 3)
  always_comb begin
    if (size <= 8'd3)
      target = {233'd0, mant} >> {(8'd3 - size), 3'b000};
    else
      target = {233'd0, mant} << {(size - 8'd3), 3'b000};
  end

  // Zero, negative or too large for 256 bits
  assign bits_err = (i_bits == 32'd0) ||
                    (mant != 23'd0 && i_bits[23]) ||
                    (mant != 23'd0 && (size > 8'd34 ||
                                       (mant > 23'hff && size > 8'd33) ||
                                       (mant > 23'hffff && size > 8'd32)));

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_val  <= 1'b0;
      o_fail <= 1'b0;
    end else begin
      o_val <= i_hash_stb;
      if (i_hash_stb)
        o_fail <= bits_err || (i_hash > target);
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_hash_stb)
      o_digest <= i_hash;
  end

endmodule

/* tb_pow_check.sv */
// ********************
// Testbench for the proof-of-work checker
// Streams headers from the pattern file and checks
// digest and verdict of every result in order
// ********************
`timescale 1ns/1ps
`include "sha256d_macros.svh"

module tb_pow_check
  import sha256d_pkg::*;
();

  localparam int MAX_CASES    = 32;
  localparam int RDY_TIMEOUT  = 1000;
  localparam int VAL_TIMEOUT  = 2000;
  localparam int QUIET_CYCLES = 400;

  logic         i_clk;
  logic         i_rst;
  stream_word_t i_word;
  logic         i_word_val;
  logic         o_word_rdy;
  logic [31:0]  i_bits;
  logic         o_val;
  logic         o_fail;
  digest_t      o_digest;

  // Cases as read from the pattern file
  int           mode_tab [MAX_CASES];
  logic [63:0]  hdr_tab  [MAX_CASES][`HDR_WORDS];
  logic [31:0]  bits_tab [MAX_CASES];
  digest_t      dig_tab  [MAX_CASES];
  logic         fail_tab [MAX_CASES];
  int           num_cases;
  int           seed;

  // Outstanding results with the oldest at the front
  digest_t      exp_dig_q [$];
  logic         exp_fail_q [$];

  pow_check_top u_dut (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_word     (i_word),
    .i_word_val (i_word_val),
    .o_word_rdy (o_word_rdy),
    .i_bits     (i_bits),
    .o_val      (o_val),
    .o_fail     (o_fail),
    .o_digest   (o_digest)
  );

  // 20 ns clock
  always #10 i_clk = ~i_clk;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_digest(input string name, input digest_t got, input digest_t exp);
    if (got !== exp)
      abort_run($sformatf("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp));
  endtask

  task automatic check_fail(input string name, input logic got, input logic exp);
    if (got !== exp)
      abort_run($sformatf("ERR t=%0t %s got=%b exp=%b", $time, name, got, exp));
  endtask

  task automatic load_patterns();
    int          fd;
    int          n;
    int          mode;
    int          fail;
    string       line;
    logic [31:0] bits;
    digest_t     dig;
    logic [63:0] w [10];
    fd = $fopen("pow_check_patterns.txt", "r");
    if (fd == 0)
      abort_run("Cannot open pow_check_patterns.txt");
    num_cases = 0;
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      // Blank and comment lines carry no case
      if (line.len() == 0 || line[0] == "#" || line[0] == "\n")
        continue;
      n = $sscanf(line, "%d %h %h %h %h %h %h %h %h %h %h %h %h %d", mode,
                  w[0], w[1], w[2], w[3], w[4], w[5], w[6], w[7], w[8], w[9],
                  bits, dig, fail);
      if (n != 14)
        abort_run("Malformed line in the pattern file");
      if (num_cases == MAX_CASES)
        abort_run("Too many cases in the pattern file");
      mode_tab[num_cases] = mode;
      for (int i = 0; i < `HDR_WORDS; i++)
        hdr_tab[num_cases][i] = w[i];
      bits_tab[num_cases] = bits;
      dig_tab[num_cases]  = dig;
      fail_tab[num_cases] = (fail != 0);
      num_cases++;
    end
    $fclose(fd);
    if (num_cases == 0)
      abort_run("Pattern file holds no cases");
  endtask

  task automatic idle_cycles(input int n);
    i_word_val = 1'b0;
    repeat (n) @(negedge i_clk);
  endtask

  // Starts on a falling edge and returns on the one after the transfer
  task automatic drive_beat(input logic [63:0] data, input logic sop, input logic eop);
    int wait_cnt;
    i_word.data = data;
    i_word.sop  = sop;
    i_word.eop  = eop;
    i_word_val  = 1'b1;
    wait_cnt    = 0;
    // Valid stays up while the packer stalls
    while (o_word_rdy !== 1'b1) begin
      @(negedge i_clk);
      wait_cnt++;
      if (wait_cnt > RDY_TIMEOUT)
        abort_run("Timed out waiting for o_word_rdy");
    end
    @(negedge i_clk);
    i_word_val = 1'b0;
  endtask

  task automatic send_header(input int idx);
    int i;
    int j;
    int extra;
    exp_dig_q.push_back(dig_tab[idx]);
    exp_fail_q.push_back(fail_tab[idx]);
    // Mode 2 appends one to three junk beats after the header
    extra = (mode_tab[idx] == 2) ? 1 + int'($unsigned($random(seed)) % 3) : 0;
    for (i = 0; i < `HDR_WORDS; i++) begin
      if (mode_tab[idx] != 0)
        idle_cycles(int'($unsigned($random(seed)) % 4));
      if (i == 0)
        i_bits = bits_tab[idx];
      drive_beat(hdr_tab[idx][i], i == 0, (i == `HDR_WORDS - 1) && (extra == 0));
    end
    for (j = 0; j < extra; j++) begin
      idle_cycles(int'($unsigned($random(seed)) % 4));
      drive_beat({$random(seed), $random(seed)}, 1'b0, j == extra - 1);
    end
  endtask

  task automatic send_all();
    int k;
    // Quiet stretch after reset where o_val must stay low
    idle_cycles(8);
    for (k = 0; k < num_cases; k++)
      send_header(k);
    i_word_val = 1'b0;
  endtask

  task automatic watch_results(input int count);
    int      k;
    int      wait_cnt;
    digest_t exp_dig;
    logic    exp_fail;
    for (k = 0; k < count; k++) begin
      wait_cnt = 0;
      @(negedge i_clk);
      while (o_val !== 1'b1) begin
        @(negedge i_clk);
        wait_cnt++;
        if (wait_cnt > VAL_TIMEOUT)
          abort_run($sformatf("Timed out waiting for o_val of result %0d", k));
      end
      if (exp_dig_q.size() == 0)
        abort_run("o_val pulsed with no header outstanding");
      exp_dig  = exp_dig_q.pop_front();
      exp_fail = exp_fail_q.pop_front();
      check_digest("o_digest", o_digest, exp_dig);
      check_fail("o_fail", o_fail, exp_fail);
    end
  endtask

  // No stray strobe once every header has reported
  task automatic check_quiet(input int n);
    repeat (n) begin
      @(negedge i_clk);
      if (o_val !== 1'b0)
        abort_run("Extra o_val pulse after the last header");
    end
  endtask

  initial begin
    i_clk      = 1'b0;
    i_rst      = 1'b1;
    i_word     = '0;
    i_word_val = 1'b0;
    i_bits     = '0;
    seed       = 32'ha7b0;
    load_patterns();
    repeat (2) @(negedge i_clk);
    i_rst = 1'b0;
    if (o_val !== 1'b0)
      abort_run("o_val is not low after reset");
    if (o_word_rdy !== 1'b1)
      abort_run("o_word_rdy is not high after reset");
    fork
      send_all();
      watch_results(num_cases);
    join
    check_quiet(QUIET_CYCLES);
    $display("STATUS: PASS");
    $finish;
  end

endmodule
